// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; (
  input  logic    clock,
  input  logic    rst_n,

  input  logic    if_arvalid,
  input  ar_req_t if_ar,
  output logic    if_arready,
  output logic    if_rvalid,
  output r_rsp_t  if_r,
  input  logic    if_rready,

  input  logic    ls_arvalid,
  input  ar_req_t ls_ar,
  output logic    ls_arready,
  output logic    ls_rvalid,
  output r_rsp_t  ls_r,
  input  logic    ls_rready,

  output logic    mem_arvalid,
  output ar_req_t mem_ar,
  input  logic    mem_arready,
  input  logic    mem_rvalid,
  input  r_rsp_t  mem_r,
  output logic    mem_rready,

  output logic    clint_arvalid,
  output ar_req_t clint_ar,
  input  logic    clint_arready,
  input  logic    clint_rvalid,
  input  r_rsp_t  clint_r,
  output logic    clint_rready
);

  arb_state_t state;
  arb_state_t state_next;
  logic       idle;
  logic       ls_is_clint;
  logic       ls_to_mem;
  logic       ls_to_clint;

  assign idle = (state == ARB_IDLE);

  // only the two mtime words live in the clint
  assign ls_is_clint = (ls_ar.addr == MTIME_LO_ADDR) || (ls_ar.addr == MTIME_HI_ADDR);

  // fetch has fixed priority, load/store only gets the bus when fetch is quiet
  assign ls_to_mem   = idle & ~if_arvalid & ls_arvalid & ~ls_is_clint;
  assign ls_to_clint = idle & ~if_arvalid & ls_arvalid & ls_is_clint;

  ////////////////////
  // request side
  ////////////////////

  assign mem_arvalid   = (idle & if_arvalid) | ls_to_mem;
  assign mem_ar        = if_arvalid ? if_ar : ls_ar;
  assign clint_arvalid = ls_to_clint;
  assign clint_ar      = ls_ar;

  assign if_arready = idle & if_arvalid & mem_arready;
  assign ls_arready = (ls_to_mem & mem_arready) | (ls_to_clint & clint_arready);

  ////////////////////
  // response side
  ////////////////////

  assign if_rvalid = (state == ARB_FETCH) & mem_rvalid;
  assign if_r      = mem_r;

  assign ls_rvalid = ((state == ARB_DATA) & mem_rvalid) | ((state == ARB_CLINT) & clint_rvalid);
  assign ls_r      = (state == ARB_CLINT) ? clint_r : mem_r;

  assign mem_rready   = ((state == ARB_FETCH) & if_rready) | ((state == ARB_DATA) & ls_rready);
  assign clint_rready = (state == ARB_CLINT) & ls_rready;

  always_comb begin
    state_next = state;
    unique case (state)
      ARB_IDLE: begin
        if (if_arvalid && if_arready) begin
          state_next = ARB_FETCH;
        end else if (ls_arvalid && ls_arready) begin
          state_next = ls_is_clint ? ARB_CLINT : ARB_DATA;
        end
      end
      ARB_FETCH: begin
        if (if_rvalid && if_rready) begin
          state_next = ARB_IDLE;  // owner released on the r handshake
        end
      end
      ARB_DATA, ARB_CLINT: begin
        if (ls_rvalid && ls_rready) begin
          state_next = ARB_IDLE;
        end
      end
      default: state_next = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= ARB_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

// ==== logic/bus_pkg.sv ====
package bus_pkg;

  ////////////////////
  // basic widths
  ////////////////////

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // one bit per byte lane
  typedef logic [1:0]  resp_t;
  typedef logic [2:0]  size_t;  // log2 of the byte count

  ////////////////////
  // channel payloads
  ////////////////////

  typedef struct packed {
    addr_t addr;
    size_t size;
  } ar_req_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_rsp_t;

  typedef struct packed {
    addr_t addr;
    size_t size;
  } aw_req_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_dat_t;

  typedef struct packed {
    resp_t resp;
  } b_rsp_t;

  typedef enum logic [1:0] {
    ARB_IDLE,   // no read outstanding
    ARB_FETCH,  // fetch read owns the sram
    ARB_DATA,   // load/store read owns the sram
    ARB_CLINT   // load/store read owns the clint
  } arb_state_t;

  ////////////////////
  // address map
  ////////////////////

  localparam addr_t MTIME_LO_ADDR = 32'h0200_0048;
  localparam addr_t MTIME_HI_ADDR = 32'h0200_004C;
  localparam addr_t SRAM_BASE     = 32'h8000_0000;
  localparam int    SRAM_WORDS    = 256;
  localparam int    SRAM_IDX_W    = $clog2(SRAM_WORDS);
  localparam addr_t SRAM_LIMIT    = SRAM_BASE + addr_t'(SRAM_WORDS * 4);  // first byte past the end

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

endpackage

// ==== logic/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer import bus_pkg::*; (
  input  logic    clock,
  input  logic    rst_n,

  input  logic    arvalid,
  input  ar_req_t ar,
  output logic    arready,

  output logic    rvalid,
  output r_rsp_t  r,
  input  logic    rready
);

  logic [63:0] mtime;
  logic        ar_fire;

  assign arready = ~rvalid;  // one read at a time
  assign ar_fire = arvalid & arready;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (ar_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  ////////////////////
  // read data
  ////////////////////

  // the half is captured at the handshake, so a stalled response does not drift
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      r.data <= ar.addr[2] ? mtime[63:32] : mtime[31:0];
      r.resp <= RESP_OKAY;
    end
  end

endmodule

// ==== logic/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top import bus_pkg::*; (
  input  logic    clock,
  input  logic    rst_n,

  input  logic    if_arvalid,
  input  ar_req_t if_ar,
  output logic    if_arready,
  output logic    if_rvalid,
  output r_rsp_t  if_r,
  input  logic    if_rready,

  input  logic    ls_arvalid,
  input  ar_req_t ls_ar,
  output logic    ls_arready,
  output logic    ls_rvalid,
  output r_rsp_t  ls_r,
  input  logic    ls_rready,
  input  logic    ls_awvalid,
  input  aw_req_t ls_aw,
  output logic    ls_awready,
  input  logic    ls_wvalid,
  input  w_dat_t  ls_w,
  output logic    ls_wready,
  output logic    ls_bvalid,
  output b_rsp_t  ls_b,
  input  logic    ls_bready
);

  logic    mem_arvalid;
  ar_req_t mem_ar;
  logic    mem_arready;
  logic    mem_rvalid;
  r_rsp_t  mem_r;
  logic    mem_rready;

  logic    clint_arvalid;
  ar_req_t clint_ar;
  logic    clint_arready;
  logic    clint_rvalid;
  r_rsp_t  clint_r;
  logic    clint_rready;

  bus_arbiter u_arbiter (
    .clock         (clock),
    .rst_n         (rst_n),
    .if_arvalid    (if_arvalid),
    .if_ar         (if_ar),
    .if_arready    (if_arready),
    .if_rvalid     (if_rvalid),
    .if_r          (if_r),
    .if_rready     (if_rready),
    .ls_arvalid    (ls_arvalid),
    .ls_ar         (ls_ar),
    .ls_arready    (ls_arready),
    .ls_rvalid     (ls_rvalid),
    .ls_r          (ls_r),
    .ls_rready     (ls_rready),
    .mem_arvalid   (mem_arvalid),
    .mem_ar        (mem_ar),
    .mem_arready   (mem_arready),
    .mem_rvalid    (mem_rvalid),
    .mem_r         (mem_r),
    .mem_rready    (mem_rready),
    .clint_arvalid (clint_arvalid),
    .clint_ar      (clint_ar),
    .clint_arready (clint_arready),
    .clint_rvalid  (clint_rvalid),
    .clint_r       (clint_r),
    .clint_rready  (clint_rready)
  );

  clint_timer u_clint (
    .clock   (clock),
    .rst_n   (rst_n),
    .arvalid (clint_arvalid),
    .ar      (clint_ar),
    .arready (clint_arready),
    .rvalid  (clint_rvalid),
    .r       (clint_r),
    .rready  (clint_rready)
  );

  // writes come only from load/store and bypass the arbiter
  sram_slave u_sram (
    .clock   (clock),
    .rst_n   (rst_n),
    .arvalid (mem_arvalid),
    .ar      (mem_ar),
    .arready (mem_arready),
    .rvalid  (mem_rvalid),
    .r       (mem_r),
    .rready  (mem_rready),
    .awvalid (ls_awvalid),
    .aw      (ls_aw),
    .awready (ls_awready),
    .wvalid  (ls_wvalid),
    .w       (ls_w),
    .wready  (ls_wready),
    .bvalid  (ls_bvalid),
    .b       (ls_b),
    .bready  (ls_bready)
  );

endmodule

// ==== logic/sram_slave.sv ====
`timescale 1ns/1ps

module sram_slave import bus_pkg::*; (
  input  logic    clock,
  input  logic    rst_n,

  input  logic    arvalid,
  input  ar_req_t ar,
  output logic    arready,
  output logic    rvalid,
  output r_rsp_t  r,
  input  logic    rready,

  input  logic    awvalid,
  input  aw_req_t aw,
  output logic    awready,
  input  logic    wvalid,
  input  w_dat_t  w,
  output logic    wready,
  output logic    bvalid,
  output b_rsp_t  b,
  input  logic    bready
);

  data_t                 mem [SRAM_WORDS];
  logic                  rd_pending;
  logic                  wr_pending;
  logic                  ar_fire;
  logic                  wr_fire;
  logic [SRAM_IDX_W-1:0] rd_idx;
  logic [SRAM_IDX_W-1:0] wr_idx;

  function automatic logic in_range(addr_t a);
    return (a >= SRAM_BASE) && (a < SRAM_LIMIT);
  endfunction

  ////////////////////
  // read channel
  ////////////////////

  assign arready = arvalid & ~rd_pending;
  assign ar_fire = arvalid & arready;
  assign rd_idx  = ar.addr[SRAM_IDX_W+1:2];  // word index, byte offset dropped
  assign rvalid  = rd_pending;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
    end else if (ar_fire) begin
      rd_pending <= 1'b1;
    end else if (rready) begin
      rd_pending <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      if (in_range(ar.addr)) begin
        r.data <= mem[rd_idx];
        r.resp <= RESP_OKAY;
      end else begin
        r.data <= '0;
        r.resp <= RESP_SLVERR;
      end
    end
  end

  ////////////////////
  // write channel
  ////////////////////

  // address and data are taken in the same cycle or not at all
  assign wr_fire = awvalid & wvalid & ~wr_pending;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign wr_idx  = aw.addr[SRAM_IDX_W+1:2];
  assign bvalid  = wr_pending;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wr_pending <= 1'b0;
    end else if (wr_fire) begin
      wr_pending <= 1'b1;
    end else if (bready) begin
      wr_pending <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      b.resp <= in_range(aw.addr) ? RESP_OKAY : RESP_SLVERR;
      if (in_range(aw.addr)) begin
        for (int i = 0; i < $bits(strb_t); i++) begin
          if (w.strb[i]) begin
            mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];  // only strobed lanes change
          end
        end
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_mem_subsystem -Mdir obj_dir

output=$(./obj_dir/Vtb_mem_subsystem) || true
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// ==== tests/mem_subsystem_assertions.sv ====
`timescale 1ns/1ps

module mem_subsystem_assertions import bus_pkg::*; (
  input logic       clock,
  input logic       rst_n,
  input logic       if_arvalid,
  input logic       if_arready,
  input logic       if_rvalid,
  input logic       if_rready,
  input r_rsp_t     if_r,
  input logic       ls_arvalid,
  input logic       ls_arready,
  input logic       ls_rvalid,
  input logic       ls_rready,
  input r_rsp_t     ls_r,
  input logic       mem_arvalid,
  input logic       mem_rvalid,
  input logic       clint_arvalid,
  input logic       clint_rvalid
);

  ////////////////////
  // response channels
  ////////////////////

  if_r_held: assert property (@(posedge clock) disable iff (!rst_n)
    if_rvalid && !if_rready |=> if_rvalid && $stable(if_r))
    else $error("fetch response changed while stalled");

  ls_r_held: assert property (@(posedge clock) disable iff (!rst_n)
    ls_rvalid && !ls_rready |=> ls_rvalid && $stable(ls_r))
    else $error("load/store response changed while stalled");

  // a response may only show up one cycle after its own master was granted
  if_owner: assert property (@(posedge clock) disable iff (!rst_n)
    $rose(if_rvalid) |-> $past(if_arvalid && if_arready))
    else $error("fetch rvalid rose without a fetch grant the cycle before");

  ls_owner: assert property (@(posedge clock) disable iff (!rst_n)
    $rose(ls_rvalid) |-> $past(ls_arvalid && ls_arready))
    else $error("load/store rvalid rose without a load/store grant the cycle before");

  one_slave: assert property (@(posedge clock) disable iff (!rst_n)
    !((mem_arvalid || mem_rvalid) && (clint_arvalid || clint_rvalid)))
    else $error("sram and clint busy with reads in the same cycle");

endmodule

bind bus_arbiter mem_subsystem_assertions u_assertions (
  .clock         (clock),
  .rst_n         (rst_n),
  .if_arvalid    (if_arvalid),
  .if_arready    (if_arready),
  .if_rvalid     (if_rvalid),
  .if_rready     (if_rready),
  .if_r          (if_r),
  .ls_arvalid    (ls_arvalid),
  .ls_arready    (ls_arready),
  .ls_rvalid     (ls_rvalid),
  .ls_rready     (ls_rready),
  .ls_r          (ls_r),
  .mem_arvalid   (mem_arvalid),
  .mem_rvalid    (mem_rvalid),
  .clint_arvalid (clint_arvalid),
  .clint_rvalid  (clint_rvalid)
);

// ==== tests/stimulus_input.hex ====
// columns: op addr wdata strb expected_data expected_resp
// op 0 write, 1 load/store read, 2 fetch read, 3 fetch of addr with load/store of wdata, ff end
00000000 80000000 11223344 0000000f 00000000 00000000
00000000 80000004 a5a5a5a5 0000000f 00000000 00000000
00000001 80000000 00000000 00000000 11223344 00000000
00000000 80000000 deadbeef 00000005 00000000 00000000
00000001 80000000 00000000 00000000 11ad33ef 00000000
00000002 80000000 00000000 00000000 11ad33ef 00000000
00000000 800003fc cafef00d 0000000f 00000000 00000000
00000002 800003fc 00000000 00000000 cafef00d 00000000
00000003 80000004 800003fc 00000000 a5a5a5a5 00000000
00000001 02000048 00000000 00000000 00000000 00000000
00000001 02000048 00000000 00000000 00000000 00000000
00000001 0200004c 00000000 00000000 00000000 00000000
00000001 02000048 00000000 00000000 00000000 00000000
00000000 80000400 12345678 0000000f 00000000 00000002
00000001 80000400 00000000 00000000 00000000 00000002
00000001 7ffffffc 00000000 00000000 00000000 00000002
00000002 02000048 00000000 00000000 00000000 00000002
00000001 02000050 00000000 00000000 00000000 00000002
00000001 80000004 00000000 00000000 a5a5a5a5 00000000
00000003 80000000 02000048 00000000 11ad33ef 00000000
000000ff 00000000 00000000 00000000 00000000 00000000

// ==== tests/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem import bus_pkg::*; ();

  localparam int MAX_VEC  = 32;
  localparam int VEC_COLS = 6;  // op, addr, wdata, strb, expected data, expected resp

  logic    clock;
  logic    rst_n;
  logic    if_arvalid;
  ar_req_t if_ar;
  logic    if_arready;
  logic    if_rvalid;
  r_rsp_t  if_r;
  logic    if_rready;
  logic    ls_arvalid;
  ar_req_t ls_ar;
  logic    ls_arready;
  logic    ls_rvalid;
  r_rsp_t  ls_r;
  logic    ls_rready;
  logic    ls_awvalid;
  aw_req_t ls_aw;
  logic    ls_awready;
  logic    ls_wvalid;
  w_dat_t  ls_w;
  logic    ls_wready;
  logic    ls_bvalid;
  b_rsp_t  ls_b;
  logic    ls_bready;

  logic [31:0] vec [MAX_VEC*VEC_COLS];
  data_t       model [SRAM_WORDS];  // expected sram contents
  int          num_vec;
  int          limit = 1000;
  int          cycles = 0;
  int          errors = 0;
  data_t       last_mtime = '0;
  logic [31:0] op;
  addr_t       addr;
  data_t       wdata;
  data_t       vdata;
  resp_t       vresp;
  strb_t       strb;
  data_t       data;
  data_t       fdata;
  resp_t       resp;
  resp_t       fresp;
  resp_t       exp_r;
  int          c_if;
  int          c_ls;

  mem_subsystem_top UUT (.*);

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic void model_write(addr_t a, data_t d, strb_t s, output resp_t r);
    addr_t off;
    off = a - SRAM_BASE;  // wraps for addresses below the base
    if (off < 32'(SRAM_WORDS * 4)) begin
      for (int i = 0; i < 4; i++) begin
        if (s[i]) model[off[9:2]][8*i +: 8] = d[8*i +: 8];
      end
      r = RESP_OKAY;
    end else begin
      r = RESP_SLVERR;
    end
  endfunction

  function automatic void model_read(addr_t a, output data_t d, output resp_t r);
    addr_t off;
    off = a - SRAM_BASE;
    d = (off < 32'(SRAM_WORDS * 4)) ? model[off[9:2]] : '0;
    r = (off < 32'(SRAM_WORDS * 4)) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  task automatic check_read(bit is_ls, string port, addr_t a, data_t d, resp_t r);
    data_t exp_d;
    resp_t exp_rr;
    if (is_ls && a == MTIME_LO_ADDR) begin
      check_value({port, " mtime_lo increasing"}, d > last_mtime, 1);
      last_mtime = d;
      exp_rr = RESP_OKAY;
    end else begin
      if (is_ls && a == MTIME_HI_ADDR) begin
        exp_d  = '0;  // the upper half stays zero in a short run
        exp_rr = RESP_OKAY;
      end else begin
        model_read(a, exp_d, exp_rr);
      end
      check_value({port, "_r.data"}, d, exp_d);
    end
    check_value({port, "_r.resp"}, r, exp_rr);
  endtask

  ////////////////////
  // bus tasks
  ////////////////////

  task automatic ls_write(addr_t a, data_t d, strb_t s, output resp_t r);
    b_rsp_t held;
    bit     seen;
    int     stall;
    @(posedge clock);
    ls_awvalid <= 1'b1;
    ls_aw      <= '{addr: a, size: 3'd2};
    ls_wvalid  <= 1'b1;
    ls_w       <= '{data: d, strb: s};
    do @(posedge clock); while (!ls_awready);
    check_value("ls_wready", ls_wready, 1'b1);  // address and data are taken together
    ls_awvalid <= 1'b0;
    ls_wvalid  <= 1'b0;
    stall = $urandom % 4;  // hold bready low a while
    seen  = 1'b0;
    repeat (stall) begin
      @(posedge clock);
      if (ls_bvalid) begin
        if (seen) check_value("ls_b while stalled", ls_b, held);
        held = ls_b;
        seen = 1'b1;
      end
    end
    ls_bready <= 1'b1;
    do @(posedge clock); while (!ls_bvalid);
    if (seen) check_value("ls_b at handshake", ls_b, held);
    r = ls_b.resp;
    ls_bready <= 1'b0;
  endtask

  task automatic ls_read(addr_t a, output data_t d, output resp_t r, output int c);
    r_rsp_t held;
    bit     seen;
    int     stall;
    @(posedge clock);
    ls_arvalid <= 1'b1;
    ls_ar      <= '{addr: a, size: 3'd2};
    do @(posedge clock); while (!ls_arready);
    c = cycles;
    ls_arvalid <= 1'b0;
    stall = $urandom % 4;
    seen  = 1'b0;
    repeat (stall) begin
      @(posedge clock);
      if (ls_rvalid) begin
        if (seen) check_value("ls_r while stalled", ls_r, held);
        held = ls_r;
        seen = 1'b1;
      end
    end
    ls_rready <= 1'b1;
    do @(posedge clock); while (!ls_rvalid);
    if (seen) check_value("ls_r at handshake", ls_r, held);
    d = ls_r.data;
    r = ls_r.resp;
    ls_rready <= 1'b0;
  endtask

  task automatic fetch_read(addr_t a, output data_t d, output resp_t r, output int c);
    r_rsp_t held;
    bit     seen;
    int     stall;
    @(posedge clock);
    if_arvalid <= 1'b1;
    if_ar      <= '{addr: a, size: 3'd2};
    do @(posedge clock); while (!if_arready);
    c = cycles;
    if_arvalid <= 1'b0;
    stall = $urandom % 4;
    seen  = 1'b0;
    repeat (stall) begin
      @(posedge clock);
      if (if_rvalid) begin
        if (seen) check_value("if_r while stalled", if_r, held);
        held = if_r;
        seen = 1'b1;
      end
    end
    if_rready <= 1'b1;
    do @(posedge clock); while (!if_rvalid);
    if (seen) check_value("if_r at handshake", if_r, held);
    d = if_r.data;
    r = if_r.resp;
    if_rready <= 1'b0;
  endtask

  initial begin
    void'($urandom(84950));
    clock      = 1'b0;
    rst_n      = 1'b0;
    if_arvalid = 1'b0;
    if_ar      = '0;
    if_rready  = 1'b0;
    ls_arvalid = 1'b0;
    ls_ar      = '0;
    ls_rready  = 1'b0;
    ls_awvalid = 1'b0;
    ls_aw      = '0;
    ls_wvalid  = 1'b0;
    ls_w       = '0;
    ls_bready  = 1'b0;
    for (int i = 0; i < SRAM_WORDS; i++) model[i] = '0;
    $readmemh("tests/stimulus_input.hex", vec);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec[VEC_COLS*num_vec] !== 32'hff) num_vec++;
    limit = 40 * num_vec + 100;
    repeat (4) @(posedge clock);
    rst_n <= 1'b1;

    for (int v = 0; v < num_vec; v++) begin
      op    = vec[VEC_COLS*v];
      addr  = vec[VEC_COLS*v + 1];
      wdata = vec[VEC_COLS*v + 2];
      strb  = vec[VEC_COLS*v + 3][3:0];
      vdata = vec[VEC_COLS*v + 4];
      vresp = vec[VEC_COLS*v + 5][1:0];
      case (op)
        32'h0: begin
          ls_write(addr, wdata, strb, resp);
          model_write(addr, wdata, strb, exp_r);
          check_value("ls_b.resp", resp, exp_r);
          check_value("vector ls_b.resp", resp, vresp);
        end
        32'h1: begin
          ls_read(addr, data, resp, c_ls);
          check_read(1'b1, "ls", addr, data, resp);
          if (addr != MTIME_LO_ADDR) check_value("vector ls_r.data", data, vdata);
          check_value("vector ls_r.resp", resp, vresp);
        end
        32'h2: begin
          fetch_read(addr, data, resp, c_if);
          check_read(1'b0, "if", addr, data, resp);
          check_value("vector if_r.data", data, vdata);
          check_value("vector if_r.resp", resp, vresp);
        end
        32'h3: begin
          fork  // the wdata column holds the load/store address here
            fetch_read(addr, fdata, fresp, c_if);
            ls_read(wdata, data, resp, c_ls);
          join
          check_read(1'b0, "if", addr, fdata, fresp);
          check_read(1'b1, "ls", wdata, data, resp);
          check_value("vector if_r.data", fdata, vdata);
          check_value("fetch granted first", c_if < c_ls, 1);
        end
        default: begin
          $display("vector %0d has an unknown operation code %0h", v, op);
          errors++;
        end
      endcase
    end

    repeat (4) @(posedge clock);
    $display("run finished with %0d error(s) over %0d vectors", errors, num_vec);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/bus_pkg.sv
logic/bus_arbiter.sv
logic/clint_timer.sv
logic/sram_slave.sv
logic/mem_subsystem_top.sv
tests/mem_subsystem_assertions.sv
tests/tb_mem_subsystem.sv
